// File: sources.f
+incdir+common
common/loader_pkg.sv
common/cnt_bus_if.sv
verilog/word_counter.sv
verilog/settings_assembler.sv
verilog/load_fsm.sv
verilog/settings_loader.sv
verification/tb_settings_loader.sv

// File: run_sim.sh
#!/bin/sh
# Build the settings loader testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=tb_settings_loader

verilator --binary --timing --assert -f sources.f --top-module "$TOP" \
    -Mdir "$OBJ_DIR" -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -qF "*** TEST FAILED ***" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
if ! grep -qF "*** TEST PASSED ***" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi
echo "Simulation passed"
exit 0

// File: verification/tb_settings_loader.sv
`include "loader_macros.svh"

module tb_settings_loader;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 13;
    localparam int WAIT_LIMIT   = 100;
    localparam logic [15:0] FAN_GPIO_MASK =
        (16'd1 << `CTL_BIT_FORCE_FAN) | (16'hF << `CTL_BIT_GPIO_IN_0);

    logic                           CLK;
    logic                           rst;
    logic                           thermo;
    logic                           stm_segment;
    logic                           mod_segment;
    logic                           stm_cycle_zero;
    logic [`WORD_W-1:0]             bus_dout = '0;
    logic                           bus_we;
    logic [`ADDR_W-1:0]             bus_addr;
    logic [`WORD_W-1:0]             bus_din;
    loader_pkg::silencer_settings_t silencer_settings;
    logic                           silencer_update;
    loader_pkg::sync_settings_t     sync_settings;
    logic                           sync_update;
    logic                           force_fan;
    logic [3:0]                     gpio_in;

    logic [`WORD_W-1:0] mem [256];
    logic [`WORD_W-1:0] rd_q = '0;
    logic               host_we;
    logic [`ADDR_W-1:0] host_addr;
    logic [`WORD_W-1:0] host_data;

    int unsigned rng_state  = 43;
    int          fail_count = 0;
    int          sil_count  = 0;
    int          sync_count = 0;
    int          sil_at_sync = 0;   // Silencer updates seen when sync updated
    logic        sil_upd_q  = 1'b0;
    logic        sync_upd_q = 1'b0;
    logic [15:0] status_q   = '0;

    loader_pkg::silencer_settings_t held_sil  = loader_pkg::SILENCER_DEFAULT;
    loader_pkg::sync_settings_t     held_sync = loader_pkg::SYNC_DEFAULT;
    loader_pkg::silencer_settings_t exp_sil;
    loader_pkg::sync_settings_t     exp_sync;

    settings_loader u_dut (
        .CLK               (CLK),
        .rst               (rst),
        .thermo            (thermo),
        .stm_segment       (stm_segment),
        .mod_segment       (mod_segment),
        .stm_cycle_zero    (stm_cycle_zero),
        .bus_dout          (bus_dout),
        .bus_we            (bus_we),
        .bus_addr          (bus_addr),
        .bus_din           (bus_din),
        .silencer_settings (silencer_settings),
        .silencer_update   (silencer_update),
        .sync_settings     (sync_settings),
        .sync_update       (sync_update),
        .force_fan         (force_fan),
        .gpio_in           (gpio_in)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        repeat (RESET_CYCLES + NUM_TESTS * 200) @(posedge CLK);
        $display("Timeout: the run did not finish within %0d cycles",
                 RESET_CYCLES + NUM_TESTS * 200);
        $display("*** TEST FAILED ***");
        $fatal(1, "Watchdog expired");
    end

    task automatic stop_with_error(input string what);
        fail_count++;
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at the first error");
    endtask

    // ######################################################################
    // Helpers and reference model
    // ######################################################################
    function automatic logic [15:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    function automatic logic [15:0] fill_word(input logic [7:0] a);
        if (a == `ADDR_CTL_FLAG)
            return 16'h0000;    // No flags raised at power up
        return {a ^ 8'h96, a};
    endfunction

    function automatic logic [15:0] pack_status(input logic th, input logic mod_seg,
                                                input logic stm_seg, input logic zero);
        logic [15:0] w;
        w    = '0;
        w[0] = th;
        w[1] = mod_seg;
        w[2] = stm_seg;
        w[3] = zero;
        return w;
    endfunction

    // Word 0 low byte is the flag, then one field per word
    function automatic loader_pkg::silencer_settings_t expected_silencer();
        loader_pkg::silencer_settings_t s;
        s.flag                       = mem[`ADDR_SILENCER_BASE][7:0];
        s.update_rate_intensity      = mem[`ADDR_SILENCER_BASE + 8'd1];
        s.update_rate_phase          = mem[`ADDR_SILENCER_BASE + 8'd2];
        s.completion_steps_intensity = mem[`ADDR_SILENCER_BASE + 8'd3];
        s.completion_steps_phase     = mem[`ADDR_SILENCER_BASE + 8'd4];
        return s;
    endfunction

    function automatic loader_pkg::sync_settings_t expected_sync();
        loader_pkg::sync_settings_t s;
        for (int k = 0; k < `SYNC_WORDS; k++)
            s.ecat_sync_time[16*k +: 16] = mem[`ADDR_SYNC_BASE + 8'(k)];
        return s;
    endfunction

    // Control memory, two read registers give the three edge latency
    always @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < 256; i++)
                mem[8'(i)] <= fill_word(8'(i));
        end else begin
            if (bus_we)
                mem[bus_addr] <= bus_din;
            if (host_we)
                mem[host_addr] <= host_data;
        end
        rd_q     <= mem[bus_addr];
        bus_dout <= rd_q;
    end

    // ######################################################################
    // Checkers
    // ######################################################################
    always @(posedge CLK) begin
        if (!rst && bus_we && bus_addr == `ADDR_FPGA_STATE) begin
            assert (bus_din == status_q)
                else stop_with_error($sformatf("ERROR t=%0t bus_din: got %h, expected %h",
                                               $time, bus_din, status_q));
        end
        status_q <= pack_status(thermo, mod_segment, stm_segment, stm_cycle_zero);
    end

    always @(posedge CLK) begin
        if (!rst) begin
            if (silencer_update) begin
                exp_sil = expected_silencer();
                assert (silencer_settings == exp_sil)
                    else stop_with_error($sformatf(
                        "ERROR t=%0t silencer_settings: got %h, expected %h",
                        $time, silencer_settings, exp_sil));
                assert (!mem[`ADDR_CTL_FLAG][`CTL_BIT_SILENCER_SET])
                    else stop_with_error("Silencer set bit still raised at silencer_update");
                held_sil  <= exp_sil;
                sil_count <= sil_count + 1;
            end else begin
                assert (silencer_settings == held_sil)
                    else stop_with_error($sformatf(
                        "ERROR t=%0t silencer_settings: got %h, expected %h",
                        $time, silencer_settings, held_sil));
            end
            if (sync_update) begin
                exp_sync = expected_sync();
                assert (sync_settings == exp_sync)
                    else stop_with_error($sformatf(
                        "ERROR t=%0t sync_settings: got %h, expected %h",
                        $time, sync_settings, exp_sync));
                assert (!mem[`ADDR_CTL_FLAG][`CTL_BIT_SYNC_SET])
                    else stop_with_error("Sync set bit still raised at sync_update");
                held_sync   <= exp_sync;
                sync_count  <= sync_count + 1;
                sil_at_sync <= sil_count;
            end else begin
                assert (sync_settings == held_sync)
                    else stop_with_error($sformatf(
                        "ERROR t=%0t sync_settings: got %h, expected %h",
                        $time, sync_settings, held_sync));
            end
            assert (!(silencer_update && sil_upd_q))
                else stop_with_error("silencer_update stayed high for more than one cycle");
            assert (!(sync_update && sync_upd_q))
                else stop_with_error("sync_update stayed high for more than one cycle");
        end
        sil_upd_q  <= silencer_update;
        sync_upd_q <= sync_update;
    end

    // ######################################################################
    // Stimulus
    // ######################################################################
    task automatic write_mem(input logic [7:0] a, input logic [15:0] d);
        host_we   <= 1'b1;
        host_addr <= a;
        host_data <= d;
        @(posedge CLK);
        host_we   <= 1'b0;
    endtask

    task automatic check_versions();
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        assert (mem[`ADDR_VERSION_MINOR] == {8'h00, `VERSION_MINOR})
            else stop_with_error($sformatf("ERROR t=%0t version minor word: got %h, expected %h",
                                           $time, mem[`ADDR_VERSION_MINOR], `VERSION_MINOR));
        assert (mem[`ADDR_VERSION_MAJOR] == {8'h00, `VERSION_MAJOR})
            else stop_with_error($sformatf("ERROR t=%0t version major word: got %h, expected %h",
                                           $time, mem[`ADDR_VERSION_MAJOR], `VERSION_MAJOR));
        @(posedge CLK);
    endtask

    task automatic check_status_word();
        logic [15:0] r;
        logic [15:0] expected;
        repeat (6) begin
            r              = next_random();
            thermo         <= r[0];
            mod_segment    <= r[1];
            stm_segment    <= r[2];
            stm_cycle_zero <= r[3];
            expected       = pack_status(r[0], r[1], r[2], r[3]);
            repeat (6) @(posedge CLK);  // Covers one full poll loop
            @(negedge CLK);
            assert (mem[`ADDR_FPGA_STATE] == expected)
                else stop_with_error($sformatf("ERROR t=%0t status word: got %h, expected %h",
                                               $time, mem[`ADDR_FPGA_STATE], expected));
            @(posedge CLK);
        end
    endtask

    task automatic check_fan_gpio(input logic [15:0] flag);
        int n;
        n = 0;
        @(negedge CLK);
        while ((force_fan !== flag[`CTL_BIT_FORCE_FAN]
                || gpio_in !== flag[`CTL_BIT_GPIO_IN_0 +: 4]) && n < 12) begin
            @(negedge CLK);
            n++;
        end
        assert (force_fan === flag[`CTL_BIT_FORCE_FAN])
            else stop_with_error($sformatf("ERROR t=%0t force_fan: got %b, expected %b",
                                           $time, force_fan, flag[`CTL_BIT_FORCE_FAN]));
        assert (gpio_in === flag[`CTL_BIT_GPIO_IN_0 +: 4])
            else stop_with_error($sformatf("ERROR t=%0t gpio_in: got %h, expected %h",
                                           $time, gpio_in, flag[`CTL_BIT_GPIO_IN_0 +: 4]));
        @(posedge CLK);
    endtask

    task automatic run_load(input bit do_sil, input bit do_sync);
        logic [15:0] flag;
        int          sil0;
        int          sync0;
        int          n;
        if (do_sil)
            for (int k = 0; k < `SILENCER_WORDS; k++)
                write_mem(`ADDR_SILENCER_BASE + 8'(k), next_random());
        if (do_sync)
            for (int k = 0; k < `SYNC_WORDS; k++)
                write_mem(`ADDR_SYNC_BASE + 8'(k), next_random());
        flag = next_random() & FAN_GPIO_MASK;
        flag[`CTL_BIT_SILENCER_SET] = do_sil;
        flag[`CTL_BIT_SYNC_SET]     = do_sync;
        sil0  = sil_count;
        sync0 = sync_count;
        write_mem(`ADDR_CTL_FLAG, flag);
        n = 0;
        while ((sil_count != sil0 + int'(do_sil) || sync_count != sync0 + int'(do_sync))
               && n < WAIT_LIMIT) begin
            @(posedge CLK);
            n++;
        end
        assert (n < WAIT_LIMIT)
            else stop_with_error("Expected settings update did not arrive after the flag write");
        if (do_sil && do_sync) begin
            assert (sil_at_sync == sil0 + 1)
                else stop_with_error("sync_update came before silencer_update");
        end
        check_fan_gpio(flag);
    endtask

    task automatic set_fan_gpio();
        logic [15:0] flag;
        flag = next_random() & FAN_GPIO_MASK;
        write_mem(`ADDR_CTL_FLAG, flag);
        check_fan_gpio(flag);
    endtask

    initial begin
        rst            <= 1'b1;
        thermo         <= 1'b0;
        stm_segment    <= 1'b0;
        mod_segment    <= 1'b0;
        stm_cycle_zero <= 1'b0;
        host_we        <= 1'b0;
        host_addr      <= '0;
        host_data      <= '0;
        repeat (RESET_CYCLES) @(posedge CLK);
        rst <= 1'b0;

        check_versions();
        check_status_word();
        repeat (3) run_load(1'b1, 1'b0);
        repeat (3) run_load(1'b0, 1'b1);
        repeat (2) run_load(1'b1, 1'b1);   // Silencer must win
        repeat (3) set_fan_gpio();
        repeat (4) @(posedge CLK);

        if (fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verilog/settings_loader.sv
`include "loader_macros.svh"

module settings_loader (
    input  logic                           CLK,
    input  logic                           rst,
    input  logic                           thermo,
    input  logic                           stm_segment,
    input  logic                           mod_segment,
    input  logic                           stm_cycle_zero,
    input  logic [`WORD_W-1:0]             bus_dout,
    output logic                           bus_we,
    output logic [`ADDR_W-1:0]             bus_addr,
    output logic [`WORD_W-1:0]             bus_din,
    output loader_pkg::silencer_settings_t silencer_settings,
    output logic                           silencer_update,
    output loader_pkg::sync_settings_t     sync_settings,
    output logic                           sync_update,
    output logic                           force_fan,
    output logic [3:0]                     gpio_in
);

    cnt_bus_if bus ();

    logic                     start;
    loader_pkg::load_target_t target;
    logic [`BURST_IDX_W-1:0]  req_idx;
    logic                     req_last;
    logic                     cap_valid;
    logic [`BURST_IDX_W-1:0]  cap_idx;
    logic                     done;
    logic                     silencer_capture;
    logic                     sync_capture;
    logic                     silencer_commit;
    logic                     sync_commit;

    assign bus.dout = bus_dout;
    assign bus_we   = bus.we;
    assign bus_addr = bus.addr;
    assign bus_din  = bus.din;

    load_fsm u_fsm (
        .CLK              (CLK),
        .rst              (rst),
        .bus              (bus),
        .thermo           (thermo),
        .stm_segment      (stm_segment),
        .mod_segment      (mod_segment),
        .stm_cycle_zero   (stm_cycle_zero),
        .start            (start),
        .target           (target),
        .req_idx          (req_idx),
        .req_last         (req_last),
        .cap_valid        (cap_valid),
        .done             (done),
        .silencer_capture (silencer_capture),
        .sync_capture     (sync_capture),
        .silencer_commit  (silencer_commit),
        .sync_commit      (sync_commit),
        .force_fan        (force_fan),
        .gpio_in          (gpio_in)
    );

    word_counter u_counter (
        .CLK       (CLK),
        .rst       (rst),
        .start     (start),
        .target    (target),
        .req_idx   (req_idx),
        .req_last  (req_last),
        .cap_valid (cap_valid),
        .cap_idx   (cap_idx),
        .done      (done)
    );

    // Word 0 lands in the top field of the silencer struct
    settings_assembler #(
        .payload_t (loader_pkg::silencer_settings_t),
        .WORDS     (`SILENCER_WORDS),
        .DEFAULT   (loader_pkg::SILENCER_DEFAULT),
        .LSW_FIRST (1'b0)
    ) u_silencer (
        .CLK      (CLK),
        .rst      (rst),
        .bus      (bus),
        .capture  (silencer_capture),
        .cap_idx  (cap_idx),
        .commit   (silencer_commit),
        .settings (silencer_settings),
        .update   (silencer_update)
    );

    settings_assembler #(
        .payload_t (loader_pkg::sync_settings_t),
        .WORDS     (`SYNC_WORDS),
        .DEFAULT   (loader_pkg::SYNC_DEFAULT),
        .LSW_FIRST (1'b1)
    ) u_sync (
        .CLK      (CLK),
        .rst      (rst),
        .bus      (bus),
        .capture  (sync_capture),
        .cap_idx  (cap_idx),
        .commit   (sync_commit),
        .settings (sync_settings),
        .update   (sync_update)
    );

endmodule

// File: verilog/load_fsm.sv
`include "loader_macros.svh"

module load_fsm (
    input  logic                     CLK,
    input  logic                     rst,
    cnt_bus_if.fsm                   bus,
    input  logic                     thermo,
    input  logic                     stm_segment,
    input  logic                     mod_segment,
    input  logic                     stm_cycle_zero,
    output logic                     start,
    output loader_pkg::load_target_t target,
    input  logic [`BURST_IDX_W-1:0]  req_idx,
    input  logic                     req_last,
    input  logic                     cap_valid,
    input  logic                     done,
    output logic                     silencer_capture,
    output logic                     sync_capture,
    output logic                     silencer_commit,
    output logic                     sync_commit,
    output logic                     force_fan,
    output logic [3:0]               gpio_in
);

    loader_pkg::fsm_state_t   state;
    loader_pkg::load_target_t cur_target;
    loader_pkg::load_target_t new_target;

    logic [`WORD_W-1:0]     ctl_flags;
    logic [`WORD_W-1:0]     status_word;
    logic [`WORD_W-1:0]     writeback_word;
    logic [`RD_LATENCY-1:0] rd_pend;      // Flag reads in flight
    logic [`ADDR_W-1:0]     base_addr;
    logic [`ADDR_W-1:0]     req_addr;
    logic                   flag_sample;
    logic                   polling;

    assign status_word = {{(`WORD_W-4){1'b0}}, stm_cycle_zero, stm_segment, mod_segment, thermo};

    assign flag_sample = rd_pend[`RD_LATENCY-1];
    assign polling     = (state == loader_pkg::ST_POLL_STATE)
                         || (state == loader_pkg::ST_POLL_FLAG);

    // ######################################################################
    // Dispatch
    // ######################################################################
    always_comb begin
        if (bus.dout[`CTL_BIT_SILENCER_SET])
            new_target = loader_pkg::TGT_SILENCER;
        else if (bus.dout[`CTL_BIT_SYNC_SET])
            new_target = loader_pkg::TGT_SYNC;
        else
            new_target = loader_pkg::TGT_NONE;
    end

    assign start  = polling && flag_sample && (new_target != loader_pkg::TGT_NONE);
    assign target = start ? new_target : cur_target;

    always_comb begin
        case (target)
            loader_pkg::TGT_SILENCER: base_addr = `ADDR_SILENCER_BASE;
            loader_pkg::TGT_SYNC:     base_addr = `ADDR_SYNC_BASE;
            default:                  base_addr = '0;
        endcase
    end

    assign req_addr = base_addr + `ADDR_W'(req_idx);

    // Serviced bit cleared
    always_comb begin
        writeback_word = ctl_flags;
        case (cur_target)
            loader_pkg::TGT_SILENCER: writeback_word[`CTL_BIT_SILENCER_SET] = 1'b0;
            loader_pkg::TGT_SYNC:     writeback_word[`CTL_BIT_SYNC_SET] = 1'b0;
            default: ;
        endcase
    end

    assign silencer_capture = cap_valid && (cur_target == loader_pkg::TGT_SILENCER);
    assign sync_capture     = cap_valid && (cur_target == loader_pkg::TGT_SYNC);
    assign silencer_commit  = (state == loader_pkg::ST_COMMIT)
                              && (cur_target == loader_pkg::TGT_SILENCER);
    assign sync_commit      = (state == loader_pkg::ST_COMMIT)
                              && (cur_target == loader_pkg::TGT_SYNC);

    assign force_fan = ctl_flags[`CTL_BIT_FORCE_FAN];
    assign gpio_in   = ctl_flags[`CTL_BIT_GPIO_IN_0 +: 4];

    // ######################################################################
    // Sequencer
    // ######################################################################
    always_ff @(posedge CLK) begin
        if (rst) begin
            state      <= loader_pkg::ST_VER_MINOR;
            cur_target <= loader_pkg::TGT_NONE;
            ctl_flags  <= '0;
            rd_pend    <= '0;
            bus.we     <= 1'b0;
            bus.addr   <= '0;
            bus.din    <= '0;
        end else begin
            rd_pend <= {rd_pend[`RD_LATENCY-2:0], 1'b0};
            if (flag_sample)
                ctl_flags <= bus.dout;

            case (state)
                loader_pkg::ST_VER_MINOR: begin
                    bus.we   <= 1'b1;
                    bus.addr <= `ADDR_VERSION_MINOR;
                    bus.din  <= {{(`WORD_W-8){1'b0}}, `VERSION_MINOR};
                    state    <= loader_pkg::ST_VER_MAJOR;
                end
                loader_pkg::ST_VER_MAJOR: begin
                    bus.addr <= `ADDR_VERSION_MAJOR;
                    bus.din  <= {{(`WORD_W-8){1'b0}}, `VERSION_MAJOR};
                    state    <= loader_pkg::ST_POLL_STATE;
                end
                loader_pkg::ST_POLL_STATE, loader_pkg::ST_POLL_FLAG: begin
                    if (start) begin
                        bus.we     <= 1'b0;
                        bus.addr   <= req_addr;       // Word 0 of the burst
                        cur_target <= new_target;
                        rd_pend    <= '0;             // Drop stale flag reads
                        state      <= loader_pkg::ST_BURST;
                    end else if (state == loader_pkg::ST_POLL_STATE) begin
                        bus.we   <= 1'b1;
                        bus.addr <= `ADDR_FPGA_STATE;
                        bus.din  <= status_word;
                        state    <= loader_pkg::ST_POLL_FLAG;
                    end else begin
                        bus.we   <= 1'b0;
                        bus.addr <= `ADDR_CTL_FLAG;
                        rd_pend  <= {rd_pend[`RD_LATENCY-2:0], 1'b1};
                        state    <= loader_pkg::ST_POLL_STATE;
                    end
                end
                loader_pkg::ST_BURST: begin
                    bus.addr <= req_addr;
                    if (req_last)
                        state <= loader_pkg::ST_DRAIN;
                end
                loader_pkg::ST_DRAIN: begin
                    if (done) begin
                        bus.we    <= 1'b1;
                        bus.addr  <= `ADDR_CTL_FLAG;
                        bus.din   <= writeback_word;
                        ctl_flags <= writeback_word;
                        state     <= loader_pkg::ST_STATUS;
                    end
                end
                loader_pkg::ST_STATUS: begin
                    bus.addr <= `ADDR_FPGA_STATE;
                    bus.din  <= status_word;
                    state    <= loader_pkg::ST_COMMIT;
                end
                loader_pkg::ST_COMMIT: begin
                    bus.we     <= 1'b0;               // Straight back to a flag read
                    bus.addr   <= `ADDR_CTL_FLAG;
                    rd_pend    <= {rd_pend[`RD_LATENCY-2:0], 1'b1};
                    cur_target <= loader_pkg::TGT_NONE;
                    state      <= loader_pkg::ST_POLL_STATE;
                end
                default: state <= loader_pkg::ST_POLL_STATE;
            endcase
        end
    end

    // Counter captures line up with the burst states
    a_cap_in_burst: assert property (@(posedge CLK) disable iff (rst)
        (cap_valid || done) |-> (state == loader_pkg::ST_BURST
                                 || state == loader_pkg::ST_DRAIN));

endmodule

// File: verilog/settings_assembler.sv
`include "loader_macros.svh"

module settings_assembler #(
    parameter type      payload_t = logic [63:0],
    parameter int       WORDS     = 4,
    parameter payload_t DEFAULT   = payload_t'(0),
    parameter bit       LSW_FIRST = 1'b1     // Word 0 in the low slice
) (
    input  logic                    CLK,
    input  logic                    rst,
    cnt_bus_if.sink                 bus,
    input  logic                    capture,
    input  logic [`BURST_IDX_W-1:0] cap_idx,
    input  logic                    commit,
    output payload_t                settings,
    output logic                    update
);

    localparam int STAGE_W = WORDS * `WORD_W;
    localparam int PAY_W   = $bits(payload_t);

    logic [STAGE_W-1:0] staging;
    int                 slot;

    // Word slot inside the staging register
    always_comb begin
        if (LSW_FIRST)
            slot = int'(cap_idx);
        else
            slot = WORDS - 1 - int'(cap_idx);
    end

    always_ff @(posedge CLK) begin
        if (capture)
            staging[slot*`WORD_W +: `WORD_W] <= bus.dout;
    end

    // ######################################################################
    // Output register
    // ######################################################################
    always_ff @(posedge CLK) begin
        if (rst) begin
            settings <= DEFAULT;
            update   <= 1'b0;
        end else begin
            update <= commit;
            if (commit)
                settings <= payload_t'(staging[PAY_W-1:0]);   // Spare top bits dropped
        end
    end

    a_update_pulse: assert property (@(posedge CLK) disable iff (rst)
        update |=> !update);

endmodule

// File: verilog/word_counter.sv
`include "loader_macros.svh"

module word_counter (
    input  logic                     CLK,
    input  logic                     rst,
    input  logic                     start,
    input  loader_pkg::load_target_t target,
    output logic [`BURST_IDX_W-1:0]  req_idx,
    output logic                     req_last,
    output logic                     cap_valid,
    output logic [`BURST_IDX_W-1:0]  cap_idx,
    output logic                     done
);

    localparam int IDX_W = `BURST_IDX_W;
    localparam int LAT   = `RD_LATENCY;

    logic             active;
    logic             issue;
    logic [IDX_W-1:0] tgt_last;
    logic [IDX_W-1:0] last_idx;     // Last index of the running burst
    logic [IDX_W-1:0] cur_last;
    logic [LAT-1:0]   vld_sr;
    logic [IDX_W-1:0] idx_sr [LAT];

    always_comb begin
        case (target)
            loader_pkg::TGT_SILENCER: tgt_last = IDX_W'(`SILENCER_WORDS - 1);
            loader_pkg::TGT_SYNC:     tgt_last = IDX_W'(`SYNC_WORDS - 1);
            default:                  tgt_last = '0;
        endcase
    end

    assign issue    = start || active;   // First word goes out on the start edge
    assign cur_last = active ? last_idx : tgt_last;
    assign req_last = issue && (req_idx == cur_last);

    always_ff @(posedge CLK) begin
        if (rst) begin
            active   <= 1'b0;
            req_idx  <= '0;
            last_idx <= '0;
            vld_sr   <= '0;
            done     <= 1'b0;
        end else begin
            if (start)
                last_idx <= tgt_last;
            if (issue) begin
                active  <= !req_last;
                req_idx <= req_last ? '0 : req_idx + IDX_W'(1);
            end
            vld_sr <= {vld_sr[LAT-2:0], issue};
            done   <= cap_valid && (cap_idx == last_idx);
        end
    end

    // Index rides along with the read in flight
    always_ff @(posedge CLK) begin
        idx_sr[0] <= req_idx;
        for (int i = 1; i < LAT; i++)
            idx_sr[i] <= idx_sr[i-1];
    end

    assign cap_valid = vld_sr[LAT-1];
    assign cap_idx   = idx_sr[LAT-1];

    a_idx_range: assert property (@(posedge CLK) disable iff (rst)
        cap_valid |-> (cap_idx <= last_idx));
    a_no_overlap: assert property (@(posedge CLK) disable iff (rst)
        start |-> !(active || (|vld_sr)));

endmodule

// File: common/cnt_bus_if.sv
`include "loader_macros.svh"

interface cnt_bus_if;

    logic                we;
    logic [`ADDR_W-1:0]  addr;
    logic [`WORD_W-1:0]  din;
    logic [`WORD_W-1:0]  dout;   // Read data, RD_LATENCY edges behind addr

    // Loader side master
    modport fsm (
        output we,
        output addr,
        output din,
        input  dout
    );

    // Read data taps for the settings assemblers
    modport sink (
        input dout
    );

endinterface

// File: common/loader_pkg.sv
package loader_pkg;

    // ######################################################################
    // Settings payloads
    // ######################################################################
    typedef struct packed {
        logic [7:0]  flag;
        logic [15:0] update_rate_intensity;
        logic [15:0] update_rate_phase;
        logic [15:0] completion_steps_intensity;
        logic [15:0] completion_steps_phase;
    } silencer_settings_t;

    typedef struct packed {
        logic [63:0] ecat_sync_time;
    } sync_settings_t;

    localparam silencer_settings_t SILENCER_DEFAULT = '{
        flag:                       8'd0,
        update_rate_intensity:      16'd256,
        update_rate_phase:          16'd256,
        completion_steps_intensity: 16'd10,
        completion_steps_phase:     16'd40
    };

    localparam sync_settings_t SYNC_DEFAULT = '{ecat_sync_time: 64'd0};

    // Block being loaded, silencer wins over sync
    typedef enum logic [1:0] {
        TGT_NONE,
        TGT_SILENCER,
        TGT_SYNC
    } load_target_t;

    typedef enum logic [2:0] {
        ST_VER_MINOR,
        ST_VER_MAJOR,
        ST_POLL_STATE,   // Status word write
        ST_POLL_FLAG,    // Flag word read request
        ST_BURST,
        ST_DRAIN,        // Wait for the last capture
        ST_STATUS,
        ST_COMMIT
    } fsm_state_t;

endpackage

// File: common/loader_macros.svh
`ifndef LOADER_MACROS_SVH
`define LOADER_MACROS_SVH

// ##########################################################################
// Control memory bus
// ##########################################################################
`define WORD_W              16
`define ADDR_W              8
`define RD_LATENCY          3       // Address edge to sample edge
`define BURST_IDX_W         3       // Wide enough for the longest burst

// ##########################################################################
// Register map
// ##########################################################################
`define ADDR_CTL_FLAG       8'h00
`define ADDR_FPGA_STATE     8'h01
`define ADDR_VERSION_MAJOR  8'h02
`define ADDR_VERSION_MINOR  8'h03
`define ADDR_SILENCER_BASE  8'h40   // Five words
`define ADDR_SYNC_BASE      8'h50   // Four words

`define VERSION_MAJOR       8'hA2
`define VERSION_MINOR       8'h01

// Control flag bits
`define CTL_BIT_SILENCER_SET 2
`define CTL_BIT_SYNC_SET     4
`define CTL_BIT_FORCE_FAN    6
`define CTL_BIT_GPIO_IN_0    8      // GPIO 1..3 follow

`define SILENCER_WORDS      5
`define SYNC_WORDS          4

`endif
